// File: src/kvs_pkg.sv
`default_nettype none

package kvs_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int key_w        = 96;
	localparam int val_w        = 32;
	localparam int slot_w       = key_w + val_w;
	localparam int n_slots      = 4;
	localparam int bucket_w     = slot_w * n_slots;
	localparam int mask_w       = bucket_w / 8;
	localparam int addr_w       = 30;
	localparam int bucket_lsb_w = 6;

	// ------------------------------------------------------------------
	// types
	// ------------------------------------------------------------------
	typedef logic [key_w-1:0]  key_t;
	typedef logic [addr_w-1:0] addr_t;

	// key sits above the value
	typedef struct packed {
		key_t             key;
		logic [val_w-1:0] value;
	} slot_t;

	// slot 0 in the lowest bits
	typedef slot_t [n_slots-1:0] bucket_t;

	typedef struct packed {
		addr_t            addr;
		key_t             key;
		logic [val_w-1:0] value;
	} set_req_t;

	typedef struct packed {
		addr_t addr;
	} get_req_t;

	typedef key_t pend_t;

	// ------------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------------
	localparam logic op_set = 1'b1;
	localparam logic op_get = 1'b0;

	localparam logic [2:0] cmd_write = 3'd0;
	localparam logic [2:0] cmd_read  = 3'd1;

	// 1 = byte not written, only slot 0 open
	localparam logic [mask_w-1:0] slot0_write_mask = 64'hffff_ffff_ffff_0000;

endpackage

`default_nettype wire

// File: src/req_fifo.sv
`default_nettype none

module req_fifo #(
	parameter int fifo_depth = 16,
	parameter type entry_t = logic
) (
	input  logic   ui_mig_clk,
	input  logic   ui_mig_rst,
	input  logic   push,
	input  entry_t push_data,
	input  logic   pop,
	output entry_t pop_data,
	output logic   empty,
	output logic   full
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);

	entry_t             mem [fifo_depth];
	logic   [ptr_w-1:0] rd_ptr;
	logic   [ptr_w-1:0] wr_ptr;
	logic   [cnt_w-1:0] count;

	// pointer advance with wrap, depth need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge ui_mig_clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// first-word fall-through head
	assign pop_data = mem[rd_ptr];
	assign empty    = (count == '0);
	assign full     = (count == cnt_w'(fifo_depth));

	// producer and consumer must respect the flags
	assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst) !(push && full));
	assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst) !(pop && empty));

endmodule

`default_nettype wire

// File: src/cmd_arbiter.sv
`default_nettype none

module cmd_arbiter (
	input  logic                        ui_mig_clk,
	input  logic                        ui_mig_rst,
	input  kvs_pkg::set_req_t           set_head,
	input  logic                        set_empty,
	output logic                        set_pop,
	input  kvs_pkg::get_req_t           get_head,
	input  logic                        get_empty,
	output logic                        get_pop,
	output logic                        app_en,
	output logic [2:0]                  app_cmd,
	output kvs_pkg::addr_t              app_addr,
	output logic                        app_wdf_wren,
	output kvs_pkg::bucket_t            app_wdf_data,
	output logic [kvs_pkg::mask_w-1:0]  app_wdf_mask,
	output logic                        app_wdf_end,
	input  logic                        app_rdy,
	input  logic                        app_wdf_rdy
);

	import kvs_pkg::*;

	logic rd_turn;
	logic can_wr;
	logic can_rd;
	logic sel_wr;
	logic sel_rd;

	// ------------------------------------------------------------------
	// alternate only while both queues hold work
	// ------------------------------------------------------------------
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			rd_turn <= 1'b1;
		else if (!set_empty && !get_empty)
			rd_turn <= !rd_turn;
	end

	assign can_wr = app_rdy && app_wdf_rdy && !set_empty;
	assign can_rd = app_rdy && !get_empty;

	always_comb begin
		sel_wr = 1'b0;
		sel_rd = 1'b0;
		if (can_wr && can_rd) begin
			sel_rd = rd_turn;
			sel_wr = !rd_turn;
		end else if (can_wr) begin
			sel_wr = 1'b1;
		end else if (can_rd) begin
			sel_rd = 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// application port
	// ------------------------------------------------------------------
	assign app_en   = sel_wr || sel_rd;
	assign app_cmd  = sel_rd ? cmd_read : cmd_write;
	assign app_addr = sel_rd ? get_head.addr : set_head.addr;

	// single-beat write, new pair lands in slot 0
	assign app_wdf_wren = sel_wr;
	assign app_wdf_end  = sel_wr;
	assign app_wdf_data = {{(bucket_w - slot_w){1'b0}}, set_head.key, set_head.value};
	assign app_wdf_mask = slot0_write_mask;

	// command accepted in the same cycle, so pop right away
	assign set_pop = sel_wr;
	assign get_pop = sel_rd;

endmodule

`default_nettype wire

// File: src/bucket_capture.sv
`default_nettype none

module bucket_capture (
	input  logic             ui_mig_clk,
	input  logic             ui_mig_rst,
	input  logic             app_rd_data_valid,
	input  kvs_pkg::bucket_t app_rd_data,
	input  kvs_pkg::key_t    pend_key,
	input  logic             pend_empty,
	output logic             pend_pop,
	output kvs_pkg::bucket_t bucket,
	output kvs_pkg::key_t    lookup_key,
	output logic             stage_valid
);

	import kvs_pkg::*;

	bucket_t bucket_q;
	key_t    key_q;

	// reads come back in order, so the head key belongs to this bucket
	assign pend_pop = app_rd_data_valid;

	always_ff @(posedge ui_mig_clk) begin
		if (app_rd_data_valid) begin
			bucket_q <= app_rd_data;
			key_q    <= pend_key;
		end
	end

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			stage_valid <= 1'b0;
		else
			stage_valid <= app_rd_data_valid;
	end

	assign bucket     = bucket_q;
	assign lookup_key = key_q;

	// every read was issued with its key already queued
	assert property (@(posedge ui_mig_clk) disable iff (ui_mig_rst)
		app_rd_data_valid |-> !pend_empty);

endmodule

`default_nettype wire

// File: src/bucket_slot.sv
`default_nettype none

module bucket_slot (
	input  logic           ui_mig_clk,
	input  logic           ui_mig_rst,
	input  kvs_pkg::slot_t slot,
	input  kvs_pkg::key_t  lookup_key,
	output logic           match
);

	import kvs_pkg::*;

	logic key_eq;

	// value field takes no part in the lookup
	assign key_eq = (slot.key == lookup_key);

	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst)
			match <= 1'b0;
		else
			match <= key_eq;
	end

endmodule

`default_nettype wire

// File: src/hit_collector.sv
`default_nettype none

module hit_collector (
	input  logic       ui_mig_clk,
	input  logic       ui_mig_rst,
	input  logic       stage_valid,
	input  logic [3:0] match,
	output logic       out_valid,
	output logic [3:0] out_flag
);

	logic valid_d1;
	logic valid_q;
	logic hit_q;

	// valid_d1 lines up with the registered slot matches
	always_ff @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			valid_d1 <= 1'b0;
			valid_q  <= 1'b0;
			hit_q    <= 1'b0;
		end else begin
			valid_d1 <= stage_valid;
			valid_q  <= valid_d1;
			hit_q    <= |match;
		end
	end

	assign out_valid = valid_q;
	// hit in bit 0, upper flag bits reserved
	assign out_flag  = {3'b000, hit_q};

endmodule

`default_nettype wire

// File: src/kvs_lookup_top.sv
`default_nettype none

module kvs_lookup_top #(
	parameter int fifo_depth = 16
) (
	input  logic                        ui_mig_clk,
	input  logic                        ui_mig_rst,
	// request side
	input  logic                        in_valid,
	input  logic [3:0]                  in_op,
	input  logic [31:0]                 in_hash,
	input  kvs_pkg::key_t               in_key,
	input  logic [kvs_pkg::val_w-1:0]   in_value,
	output logic                        in_ready,
	output logic                        out_valid,
	output logic [3:0]                  out_flag,
	// application port
	output logic                        app_en,
	output logic [2:0]                  app_cmd,
	output kvs_pkg::addr_t              app_addr,
	input  logic                        app_rdy,
	output logic                        app_wdf_wren,
	output kvs_pkg::bucket_t            app_wdf_data,
	output logic [kvs_pkg::mask_w-1:0]  app_wdf_mask,
	output logic                        app_wdf_end,
	input  logic                        app_wdf_rdy,
	input  logic                        app_rd_data_valid,
	input  kvs_pkg::bucket_t            app_rd_data
);

	import kvs_pkg::*;

	logic     accept;
	logic     is_set;
	addr_t    req_addr;
	set_req_t set_in;
	get_req_t get_in;

	set_req_t set_head;
	get_req_t get_head;
	pend_t    pend_head;
	logic     set_push, set_pop, set_empty, set_full;
	logic     get_push, get_pop, get_empty, get_full;
	logic     pend_pop, pend_empty, pend_full;

	bucket_t             bucket;
	key_t                lookup_key;
	logic                stage_valid;
	logic [n_slots-1:0]  match;

	// ------------------------------------------------------------------
	// request split
	// ------------------------------------------------------------------
	assign in_ready = !set_full && !get_full && !pend_full;
	assign accept   = in_valid && in_ready;
	assign is_set   = (in_op[0] == op_set);
	assign set_push = accept && is_set;
	assign get_push = accept && !is_set;

	// bucket aligned address from the hash
	assign req_addr = {in_hash[addr_w-1:bucket_lsb_w], {bucket_lsb_w{1'b0}}};
	assign set_in   = '{addr: req_addr, key: in_key, value: in_value};
	assign get_in   = '{addr: req_addr};

	// ------------------------------------------------------------------
	// queues
	// ------------------------------------------------------------------
	req_fifo #(.fifo_depth(fifo_depth), .entry_t(set_req_t)) set_fifo_inst (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.push(set_push), .push_data(set_in),
		.pop(set_pop), .pop_data(set_head),
		.empty(set_empty), .full(set_full)
	);

	req_fifo #(.fifo_depth(fifo_depth), .entry_t(get_req_t)) get_fifo_inst (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.push(get_push), .push_data(get_in),
		.pop(get_pop), .pop_data(get_head),
		.empty(get_empty), .full(get_full)
	);

	// key waits here until its bucket comes back
	req_fifo #(.fifo_depth(fifo_depth), .entry_t(pend_t)) pend_fifo_inst (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.push(get_push), .push_data(in_key),
		.pop(pend_pop), .pop_data(pend_head),
		.empty(pend_empty), .full(pend_full)
	);

	cmd_arbiter cmd_arbiter_inst (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.set_head(set_head), .set_empty(set_empty), .set_pop(set_pop),
		.get_head(get_head), .get_empty(get_empty), .get_pop(get_pop),
		.app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
		.app_wdf_wren(app_wdf_wren), .app_wdf_data(app_wdf_data),
		.app_wdf_mask(app_wdf_mask), .app_wdf_end(app_wdf_end),
		.app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy)
	);

	// ------------------------------------------------------------------
	// lookup pipeline, three stages
	// ------------------------------------------------------------------
	bucket_capture bucket_capture_inst (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data),
		.pend_key(pend_head), .pend_empty(pend_empty), .pend_pop(pend_pop),
		.bucket(bucket), .lookup_key(lookup_key), .stage_valid(stage_valid)
	);

	for (genvar i = 0; i < n_slots; i++) begin : g_slot
		bucket_slot bucket_slot_inst (
			.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
			.slot(bucket[i]), .lookup_key(lookup_key), .match(match[i])
		);
	end

	hit_collector hit_collector_inst (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.stage_valid(stage_valid), .match(match),
		.out_valid(out_valid), .out_flag(out_flag)
	);

endmodule

`default_nettype wire

// File: verif/kvs_checker.sv
`default_nettype none

module kvs_checker #(
	parameter int fifo_depth = 16,
	parameter int n_req      = 40
) (
	input  logic          ui_mig_clk,
	input  logic          ui_mig_rst,
	input  logic          in_valid,
	input  logic          in_ready,
	input  logic [3:0]    in_op,
	input  logic [31:0]   in_hash,
	input  kvs_pkg::key_t in_key,
	input  logic          out_valid,
	input  logic [3:0]    out_flag,
	input  logic          app_en,
	input  logic          app_rdy,
	input  logic [2:0]    app_cmd,
	input  logic          app_wdf_wren,
	input  logic          app_wdf_end,
	input  logic          app_wdf_rdy,
	input  logic          app_rd_data_valid,
	input  logic          end_of_test,
	output int            errors,
	output int            checks,
	output int            pending,
	output logic          timed_out
);

	import kvs_pkg::*;

	localparam int cycle_limit = 200 * n_req + 500;

	key_t       table_key [8][n_slots];
	logic       exp_q [$];
	logic       exp_hit;
	logic       hit;
	logic [2:0] bkt;
	int         err_cnt = 0;
	int         chk_cnt = 0;
	int         gets_seen = 0;
	int         results_seen = 0;
	int         cycles = 0;
	int         set_cnt = 0;
	int         get_cnt = 0;
	int         pend_cnt = 0;
	logic       final_done = 1'b0;

	// same preload pattern as the DRAM model
	initial begin
		for (int b = 0; b < 8; b++)
			for (int s = 0; s < n_slots; s++)
				table_key[b][s] = {48'h0, 16'h5eed, 16'(b), 16'(s)};
	end

	always @(posedge ui_mig_clk) begin
		cycles = cycles + 1;
		if (ui_mig_rst) begin
			set_cnt  = 0;
			get_cnt  = 0;
			pend_cnt = 0;
		end else begin
			// ------------------------------------------------------------------
			// back-pressure, mirrored queue fill levels
			// ------------------------------------------------------------------
			if (!in_ready && set_cnt < fifo_depth && get_cnt < fifo_depth
					&& pend_cnt < fifo_depth) begin
				$display("in_ready low at cycle %0d while no queue is full", cycles);
				err_cnt++;
			end
			if (in_valid && in_ready) begin
				bkt = in_hash[8:6];
				if (in_op[0] == op_set) begin
					// a set always lands in slot 0
					table_key[bkt][0] = in_key;
					set_cnt++;
				end else begin
					hit = 1'b0;
					for (int s = 0; s < n_slots; s++)
						if (table_key[bkt][s] == in_key)
							hit = 1'b1;
					exp_q.push_back(hit);
					get_cnt++;
					pend_cnt++;
					gets_seen++;
				end
			end
			if (app_en && app_rdy) begin
				if (app_cmd == cmd_write)
					set_cnt--;
				else
					get_cnt--;
			end
			if (app_rd_data_valid)
				pend_cnt--;

			// write data goes with its command in the same cycle
			if (app_en && app_rdy && app_cmd == cmd_write
					&& !(app_wdf_wren && app_wdf_end && app_wdf_rdy)) begin
				$display("write accepted at cycle %0d without its write data", cycles);
				err_cnt++;
			end
			if (app_wdf_wren && !(app_en && app_rdy && app_cmd == cmd_write)) begin
				$display("write data at cycle %0d without an accepted write", cycles);
				err_cnt++;
			end

			// ------------------------------------------------------------------
			// results, one per get in request order
			// ------------------------------------------------------------------
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("out_valid at cycle %0d with no get outstanding", cycles);
					err_cnt++;
				end else begin
					exp_hit = exp_q.pop_front();
					chk_cnt++;
					if (out_flag !== {3'b000, exp_hit}) begin
						$display("[FAIL] hit flag of get %0d expected %h actual %h",
							results_seen, {3'b000, exp_hit}, out_flag);
						err_cnt++;
					end
				end
				results_seen++;
			end
			if (end_of_test && !final_done) begin
				final_done = 1'b1;
				chk_cnt++;
				if (results_seen != gets_seen) begin
					$display("%0d gets accepted but %0d results seen", gets_seen, results_seen);
					err_cnt++;
				end
			end
		end
		errors    <= err_cnt;
		checks    <= chk_cnt;
		pending   <= exp_q.size();
		timed_out <= (cycles >= cycle_limit);
	end

endmodule

`default_nettype wire

// File: verif/tb_kvs_lookup.sv
`default_nettype none

module tb_kvs_lookup;

	import kvs_pkg::*;

	localparam int fifo_depth = 16;
	localparam int n_sets     = 20;
	localparam int n_gets     = 20;

	logic                ui_mig_clk;
	logic                ui_mig_rst;
	logic                in_valid;
	logic [3:0]          in_op;
	logic [31:0]         in_hash;
	key_t                in_key;
	logic [val_w-1:0]    in_value;
	logic                in_ready;
	logic                out_valid;
	logic [3:0]          out_flag;
	logic                app_en;
	logic [2:0]          app_cmd;
	addr_t               app_addr;
	logic                app_rdy;
	logic                app_wdf_wren;
	bucket_t             app_wdf_data;
	logic [mask_w-1:0]   app_wdf_mask;
	logic                app_wdf_end;
	logic                app_wdf_rdy;
	logic                app_rd_data_valid;
	bucket_t             app_rd_data;

	logic                end_of_test;
	int                  errors;
	int                  checks;
	int                  pending;
	logic                timed_out;

	int                  seed;
	int                  dram_seed;
	key_t                set_key [n_sets];
	logic [2:0]          set_bkt [n_sets];
	int                  pick;
	int                  j;
	logic [2:0]          bkt;

	// DRAM model state
	logic [bucket_w-1:0] mem [8];
	logic [bucket_w-1:0] rd_q [$];
	int                  due_q [$];
	int                  now;
	int                  last_due;
	int                  due;
	int                  idle_cycles;
	logic [2:0]          idx;
	logic [bucket_w-1:0] wdata;

	kvs_lookup_top #(.fifo_depth(fifo_depth)) kvs_lookup_top_inst (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.in_valid(in_valid), .in_op(in_op), .in_hash(in_hash),
		.in_key(in_key), .in_value(in_value), .in_ready(in_ready),
		.out_valid(out_valid), .out_flag(out_flag),
		.app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr), .app_rdy(app_rdy),
		.app_wdf_wren(app_wdf_wren), .app_wdf_data(app_wdf_data),
		.app_wdf_mask(app_wdf_mask), .app_wdf_end(app_wdf_end),
		.app_wdf_rdy(app_wdf_rdy), .app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data)
	);

	kvs_checker #(.fifo_depth(fifo_depth), .n_req(n_sets + n_gets)) kvs_checker_inst (
		.ui_mig_clk(ui_mig_clk), .ui_mig_rst(ui_mig_rst),
		.in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
		.in_hash(in_hash), .in_key(in_key),
		.out_valid(out_valid), .out_flag(out_flag),
		.app_en(app_en), .app_rdy(app_rdy), .app_cmd(app_cmd),
		.app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid), .end_of_test(end_of_test),
		.errors(errors), .checks(checks), .pending(pending), .timed_out(timed_out)
	);

	initial ui_mig_clk = 1'b0;
	always #5 ui_mig_clk = ~ui_mig_clk;

	// keys built from bucket and slot index
	function automatic key_t preload_key(input int b, input int s);
		return {48'h0, 16'h5eed, 16'(b), 16'(s)};
	endfunction

	// holds the request until the DUT takes it
	task automatic send_request(input logic op, input logic [2:0] b, input key_t key);
		logic [31:0] h;
		h = $random(seed);
		h[8:6] = b;
		in_valid <= 1'b1;
		in_op    <= {3'b000, op};
		in_hash  <= h;
		in_key   <= key;
		in_value <= $random(seed);
		@(posedge ui_mig_clk);
		while (!in_ready)
			@(posedge ui_mig_clk);
		in_valid <= 1'b0;
		if (($random(seed) & 3) == 0)
			@(posedge ui_mig_clk);
	endtask

	// ------------------------------------------------------------------
	// DRAM model behind the application port
	// ------------------------------------------------------------------
	always @(posedge ui_mig_clk) begin
		if (ui_mig_rst) begin
			app_rdy           <= 1'b0;
			app_wdf_rdy       <= 1'b0;
			app_rd_data_valid <= 1'b0;
			idle_cycles       <= 0;
			now = 0;
			last_due = 0;
		end else begin
			now = now + 1;
			if (app_en && app_rdy) begin
				idx = app_addr[8:6];
				if (app_cmd == cmd_write) begin
					wdata = app_wdf_data;
					for (int b = 0; b < mask_w; b++)
						if (!app_wdf_mask[b])
							mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
				end else begin
					// 2 to 9 cycles, never ahead of an older read
					due = now + 2 + ($unsigned($random(dram_seed)) % 8);
					if (due <= last_due)
						due = last_due + 1;
					last_due = due;
					rd_q.push_back(mem[idx]);
					due_q.push_back(due);
				end
			end
			app_rd_data_valid <= 1'b0;
			if (due_q.size() != 0 && due_q[0] <= now) begin
				app_rd_data_valid <= 1'b1;
				app_rd_data       <= rd_q.pop_front();
				void'(due_q.pop_front());
			end
			if (app_en || due_q.size() != 0)
				idle_cycles <= 0;
			else if (app_rdy && app_wdf_rdy)
				idle_cycles <= idle_cycles + 1;
			app_rdy     <= ($random(dram_seed) & 3) != 0;
			app_wdf_rdy <= ($random(dram_seed) & 3) != 0;
		end
	end

	always @(posedge ui_mig_clk) begin
		if (timed_out) begin
			$display("run stopped, results still missing at the cycle limit");
			$display("closing: %0d errors in %0d checks", errors, checks);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial begin
		seed        = 69;
		dram_seed   = 69 * 3;
		ui_mig_rst  = 1'b1;
		in_valid    = 1'b0;
		in_op       = '0;
		in_hash     = '0;
		in_key      = '0;
		in_value    = '0;
		app_rdy     = 1'b0;
		app_wdf_rdy = 1'b0;
		app_rd_data_valid = 1'b0;
		app_rd_data = '0;
		end_of_test = 1'b0;
		for (int b = 0; b < 8; b++)
			for (int s = 0; s < n_slots; s++)
				mem[b][s*slot_w +: slot_w] = {preload_key(b, s), 32'(b * n_slots + s)};
		repeat (4) @(posedge ui_mig_clk);
		ui_mig_rst <= 1'b0;

		// set phase, some buckets get hit twice
		for (int i = 0; i < n_sets; i++) begin
			set_bkt[i] = 3'($random(seed));
			set_key[i] = {$random(seed), $random(seed), $random(seed)};
			send_request(op_set, set_bkt[i], set_key[i]);
		end
		while (idle_cycles < 20)
			@(posedge ui_mig_clk);

		// get phase: set keys, preloaded slots 1-3, slot 0, unknown keys
		for (int i = 0; i < n_gets; i++) begin
			pick = $unsigned($random(seed)) % 4;
			j    = $unsigned($random(seed)) % n_sets;
			bkt  = 3'($random(seed));
			case (pick)
				0: send_request(op_get, set_bkt[j], set_key[j]);
				1: send_request(op_get, bkt, preload_key(bkt, 1 + j % 3));
				2: send_request(op_get, bkt, preload_key(bkt, 0));
				default: send_request(op_get, bkt, {$random(seed), $random(seed), $random(seed)});
			endcase
		end

		repeat (2) @(posedge ui_mig_clk);
		while (pending != 0)
			@(posedge ui_mig_clk);
		repeat (10) @(posedge ui_mig_clk);
		end_of_test <= 1'b1;
		repeat (2) @(posedge ui_mig_clk);
		$display("closing: %0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
src/kvs_pkg.sv
src/req_fifo.sv
src/cmd_arbiter.sv
src/bucket_capture.sv
src/bucket_slot.sv
src/hit_collector.sv
src/kvs_lookup_top.sv
verif/kvs_checker.sv
verif/tb_kvs_lookup.sv

// File: Bender.yml
package:
  name: kvs_lookup

sources:
  - src/kvs_pkg.sv
  - src/req_fifo.sv
  - src/cmd_arbiter.sv
  - src/bucket_capture.sv
  - src/bucket_slot.sv
  - src/hit_collector.sv
  - src/kvs_lookup_top.sv
  - target: test
    files:
      - verif/kvs_checker.sv
      - verif/tb_kvs_lookup.sv
